//--- dv/tb_model.svh
// reference register file, reference issue queue and expected dispatch packet
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

  fe_entry_s         model_q [$];
  logic [xlen_c-1:0] model_regs [32];

  task automatic model_reset();
    model_q.delete();
    for (int r = 0; r < 32; r++)
      model_regs[r] = '0;
  endtask

  function automatic logic [xlen_c-1:0] model_read(input logic [reg_addr_width_c-1:0] addr);
    // x0 is hardwired
    if (addr == '0)
      return '0;
    return model_regs[addr];
  endfunction

  // late wb, then resume, then irq, then the queue head
  function automatic dispatch_pkt_s expected_dispatch();
    dispatch_pkt_s pkt;
    fe_entry_s     head;
    logic          queued;
    pkt    = '0;
    head   = '0;
    queued = (model_q.size() != 0) && !hazard_i;
    if (model_q.size() != 0)
      head = model_q[0];

    if (late_wb_v_i && (late_wb_force_i || !queued))
      pkt.src = e_src_late_wb;
    else if (resume_i && !late_wb_v_i && !hazard_i)
      pkt.src = e_src_resume;
    else if (irq_pending_i && !late_wb_v_i && !hazard_i)
      pkt.src = e_src_irq;
    else if (queued)
      pkt.src = (head.exc == e_exc_none) ? e_src_fe_instr : e_src_fe_exc;
    else
      pkt.src = e_src_idle;
    pkt.v = (pkt.src != e_src_idle);

    case (pkt.src)
      e_src_late_wb:
      begin
        pkt.rs1        = late_wb_i.rd_data;
        pkt.wb_rd_addr = late_wb_i.rd_addr;
        pkt.wb_w_v     = late_wb_i.w_v;
      end
      e_src_fe_instr:
      begin
        pkt.pc    = head.pc;
        pkt.instr = head.instr;
        pkt.rs1   = model_read(head.instr[rs1_lsb_c +: reg_addr_width_c]);
        pkt.rs2   = model_read(head.instr[rs2_lsb_c +: reg_addr_width_c]);
      end
      e_src_fe_exc:
      begin
        pkt.pc    = head.pc;
        pkt.instr = head.instr;
        pkt.exc   = head.exc;
      end
      default: ;
    endcase
    return pkt;
  endfunction

  // one clock edge of the reference queue and register file
  task automatic model_advance(input dispatch_src_e src);
    logic room;
    room = (model_q.size() < queue_depth_c);
    if (clear_i)
      model_q.delete();
    else
    begin
      if ((src == e_src_fe_instr) || (src == e_src_fe_exc))
        void'(model_q.pop_front());
      if (fe_v_i && room)
        model_q.push_back(fe_entry_i);
    end
    if (iwb_i.w_v && (iwb_i.rd_addr != '0))
      model_regs[iwb_i.rd_addr] = iwb_i.rd_data;
  endtask

`endif

//--- dv/tb_be_scheduler.sv
// testbench for the issue scheduler with compare process, directed cases and random mix
`timescale 1ns/1ps
`default_nettype none

module tb_be_scheduler;

  import sched_pkg::*;

  localparam int queue_depth_c = 4;
  localparam int timeout_c     = 200;

  logic          clk_i = 1'b0;
  logic          rst_i = 1'b1;
  fe_entry_s     fe_entry_i;
  logic          fe_v_i;
  logic          fe_ready_o;
  wb_pkt_s       iwb_i;
  wb_pkt_s       late_wb_i;
  logic          late_wb_v_i;
  logic          late_wb_force_i;
  logic          late_wb_yumi_o;
  logic          hazard_i;
  logic          resume_i;
  logic          irq_pending_i;
  logic          clear_i;
  dispatch_pkt_s dispatch_pkt_o;
  dispatch_pkt_s exp_pkt;
  integer        seed = 40072;

  `include "tb_model.svh"

  be_scheduler #(.queue_depth_p(queue_depth_c)) be_scheduler_i (.*);

  always #50 clk_i = ~clk_i;

  task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at time %0t: %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "timeout");
  endtask

  // outputs are compared before the edge updates any state
  always @(posedge clk_i)
  begin
    if (rst_i)
      model_reset();
    else
    begin
      exp_pkt = expected_dispatch();
      check_value(256'(dispatch_pkt_o), 256'(exp_pkt), "dispatch packet");
      check_value(256'(late_wb_yumi_o), 256'(exp_pkt.src == e_src_late_wb), "late_wb_yumi_o");
      check_value(256'(fe_ready_o), 256'(model_q.size() < queue_depth_c), "fe_ready_o");
      model_advance(exp_pkt.src);
    end
  end

  task automatic set_idle_inputs();
    fe_entry_i      = '0;
    fe_v_i          = 1'b0;
    iwb_i           = '0;
    late_wb_i       = '0;
    late_wb_v_i     = 1'b0;
    late_wb_force_i = 1'b0;
    hazard_i        = 1'b0;
    resume_i        = 1'b0;
    irq_pending_i   = 1'b0;
    clear_i         = 1'b0;
  endtask

  function automatic wb_pkt_s random_wb();
    wb_pkt_s pkt;
    pkt.w_v     = 1'($random(seed));
    pkt.rd_addr = 5'($random(seed));
    pkt.rd_data = {$random(seed), $random(seed)};
    return pkt;
  endfunction

  function automatic fe_entry_s random_entry(input fetch_exc_e exc);
    fe_entry_s entry;
    entry.pc    = 39'({$random(seed), $random(seed)});
    entry.instr = $random(seed);
    entry.exc   = exc;
    return entry;
  endfunction

  task automatic push_entry(input fe_entry_s entry);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!fe_ready_o)
    begin
      waited++;
      if (waited > timeout_c)
        stop_on_timeout("fetch queue never became ready");
      @(negedge clk_i);
    end
    fe_entry_i = entry;
    fe_v_i     = 1'b1;
    @(negedge clk_i);
    fe_v_i = 1'b0;
  endtask

  task automatic wait_queue_drained();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (model_q.size() != 0)
    begin
      waited++;
      if (waited > timeout_c)
        stop_on_timeout("issue queue never drained");
      @(negedge clk_i);
    end
  endtask

  task automatic send_late_wb(input logic force_wb);
    int waited;
    waited = 0;
    @(negedge clk_i);
    late_wb_i       = random_wb();
    late_wb_v_i     = 1'b1;
    late_wb_force_i = force_wb;
    @(posedge clk_i);
    while (!late_wb_yumi_o)
    begin
      waited++;
      if (waited > timeout_c)
        stop_on_timeout("late writeback was never accepted");
      @(posedge clk_i);
    end
    @(negedge clk_i);
    late_wb_v_i     = 1'b0;
    late_wb_force_i = 1'b0;
  endtask

  task automatic fill_registers_and_issue();
    fe_entry_s entry;
    for (int k = 0; k < 40; k++)
    begin
      @(negedge clk_i);
      iwb_i     = random_wb();
      iwb_i.w_v = 1'b1;
    end
    @(negedge clk_i);
    iwb_i    = '0;
    // first entries are held so several wait in the queue together
    hazard_i = 1'b1;
    for (int k = 0; k < 8; k++)
    begin
      entry = random_entry(e_exc_none);
      // a few x0 operands
      if (k == 0)
        entry.instr[rs1_lsb_c +: reg_addr_width_c] = '0;
      if (k == 1)
        entry.instr[rs2_lsb_c +: reg_addr_width_c] = '0;
      push_entry(entry);
      if (k == queue_depth_c - 1)
        hazard_i = 1'b0;
    end
    wait_queue_drained();
  endtask

  task automatic late_wb_cases();
    // under hazard nothing counts as queued
    @(negedge clk_i);
    hazard_i = 1'b1;
    push_entry(random_entry(e_exc_none));
    send_late_wb(1'b0);
    push_entry(random_entry(e_exc_none));
    push_entry(random_entry(e_exc_none));
    hazard_i = 1'b0;
    send_late_wb(1'b1);
    wait_queue_drained();

    // force low waits for the queue to empty
    @(negedge clk_i);
    hazard_i = 1'b1;
    for (int k = 0; k < 3; k++)
      push_entry(random_entry(e_exc_none));
    hazard_i = 1'b0;
    send_late_wb(1'b0);
    wait_queue_drained();
  endtask

  task automatic resume_irq_case();
    @(negedge clk_i);
    hazard_i      = 1'b1;
    resume_i      = 1'b1;
    irq_pending_i = 1'b1;
    repeat (3) @(negedge clk_i);
    hazard_i = 1'b0;
    @(negedge clk_i);
    resume_i = 1'b0;
    @(negedge clk_i);
    irq_pending_i = 1'b0;
  endtask

  task automatic exception_case();
    push_entry(random_entry(e_exc_access_fault));
    push_entry(random_entry(e_exc_page_fault));
    push_entry(random_entry(e_exc_illegal_instr));
    wait_queue_drained();
  endtask

  task automatic full_and_clear_case();
    @(negedge clk_i);
    hazard_i = 1'b1;
    for (int k = 0; k < queue_depth_c; k++)
      push_entry(random_entry(e_exc_none));
    check_value(256'(fe_ready_o), 256'(0), "fe_ready_o with a full queue");
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i  = 1'b0;
    hazard_i = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  task automatic run_random_mix(input int cycles);
    logic       wb_taken;
    fetch_exc_e exc;
    wb_taken = 1'b1;
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge clk_i);
      // a late writeback is held until its yumi
      if (!late_wb_v_i || wb_taken)
      begin
        late_wb_i       = random_wb();
        late_wb_v_i     = ($random(seed) % 4) == 0;
        late_wb_force_i = ($random(seed) % 2) == 0;
      end
      exc = e_exc_none;
      if (($random(seed) % 4) == 0)
        exc = fetch_exc_e'(2'($random(seed)));
      fe_entry_i    = random_entry(exc);
      fe_v_i        = ($random(seed) % 2) == 0;
      iwb_i         = random_wb();
      hazard_i      = ($random(seed) % 3) == 0;
      resume_i      = ($random(seed) % 8) == 0;
      irq_pending_i = ($random(seed) % 8) == 0;
      clear_i       = ($random(seed) % 32) == 0;
      @(posedge clk_i);
      wb_taken = late_wb_yumi_o;
    end
    @(negedge clk_i);
    set_idle_inputs();
  endtask

  initial
  begin
    set_idle_inputs();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    fill_registers_and_issue();
    late_wb_cases();
    resume_irq_case();
    exception_case();
    full_and_clear_case();
    run_random_mix(2000);

    wait_queue_drained();
    repeat (2) @(negedge clk_i);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+dv
source/sched_pkg.sv
source/issue_queue.sv
source/int_regfile.sv
source/sched_control.sv
source/dispatch_former.sv
source/be_scheduler.sv
dv/tb_be_scheduler.sv

//--- run.sh
#!/bin/sh
# build and run the issue scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module tb_be_scheduler -o tb_be_scheduler

./obj_dir/tb_be_scheduler

//--- source/be_scheduler.sv
// scheduler top level with issue queue, register file, control and dispatch former
`timescale 1ns/1ps
`default_nettype none

module be_scheduler
  #(parameter int queue_depth_p = 4
   )
  (input  logic                        clk_i
   , input  logic                      rst_i

   , input  sched_pkg::fe_entry_s      fe_entry_i
   , input  logic                      fe_v_i
   , output logic                      fe_ready_o

   , input  sched_pkg::wb_pkt_s        iwb_i

   , input  sched_pkg::wb_pkt_s        late_wb_i
   , input  logic                      late_wb_v_i
   , input  logic                      late_wb_force_i
   , output logic                      late_wb_yumi_o

   , input  logic                      hazard_i
   , input  logic                      resume_i
   , input  logic                      irq_pending_i
   , input  logic                      clear_i

   , output sched_pkg::dispatch_pkt_s  dispatch_pkt_o
   );

  import sched_pkg::*;

  fe_entry_s                   head;
  logic                        head_v;
  logic                        pop;
  dispatch_src_e               src;
  logic [reg_addr_width_c-1:0] rs1_addr, rs2_addr;
  logic [xlen_c-1:0]           rs1_data, rs2_data;

  issue_queue
   #(.queue_depth_p(queue_depth_p))
   issue_queue_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.fe_entry_i(fe_entry_i)
     ,.fe_v_i(fe_v_i)
     ,.fe_ready_o(fe_ready_o)
     ,.pop_i(pop)
     ,.clear_i(clear_i)
     ,.head_v_o(head_v)
     ,.head_o(head)
     );

  int_regfile
   int_regfile_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.wb_i(iwb_i)
     ,.rs1_addr_i(rs1_addr)
     ,.rs2_addr_i(rs2_addr)
     ,.rs1_data_o(rs1_data)
     ,.rs2_data_o(rs2_data)
     );

  sched_control
   sched_control_i
    (.head_v_i(head_v)
     ,.head_exc_i(head.exc)
     ,.late_wb_v_i(late_wb_v_i)
     ,.late_wb_force_i(late_wb_force_i)
     ,.hazard_i(hazard_i)
     ,.resume_i(resume_i)
     ,.irq_pending_i(irq_pending_i)
     ,.src_o(src)
     ,.pop_o(pop)
     ,.late_wb_yumi_o(late_wb_yumi_o)
     );

  dispatch_former
   dispatch_former_i
    (.src_i(src)
     ,.head_i(head)
     ,.late_wb_i(late_wb_i)
     ,.rs1_data_i(rs1_data)
     ,.rs2_data_i(rs2_data)
     ,.rs1_addr_o(rs1_addr)
     ,.rs2_addr_o(rs2_addr)
     ,.dispatch_pkt_o(dispatch_pkt_o)
     );

endmodule

`default_nettype wire

//--- source/dispatch_former.sv
// dispatch packet assembly and source register address extraction
`timescale 1ns/1ps
`default_nettype none

module dispatch_former
  (input  sched_pkg::dispatch_src_e               src_i
   , input  sched_pkg::fe_entry_s                 head_i
   , input  sched_pkg::wb_pkt_s                   late_wb_i

   , input  logic [sched_pkg::xlen_c-1:0]         rs1_data_i
   , input  logic [sched_pkg::xlen_c-1:0]         rs2_data_i
   , output logic [sched_pkg::reg_addr_width_c-1:0] rs1_addr_o
   , output logic [sched_pkg::reg_addr_width_c-1:0] rs2_addr_o

   , output sched_pkg::dispatch_pkt_s             dispatch_pkt_o
   );

  import sched_pkg::*;

  // operands are read for whatever sits at the head
  assign rs1_addr_o = head_i.instr[rs1_lsb_c +: reg_addr_width_c];
  assign rs2_addr_o = head_i.instr[rs2_lsb_c +: reg_addr_width_c];

  always_comb
  begin
    dispatch_pkt_o     = '0;
    dispatch_pkt_o.v   = (src_i != e_src_idle);
    dispatch_pkt_o.src = src_i;

    case (src_i)
      e_src_fe_instr:
      begin
        dispatch_pkt_o.pc    = head_i.pc;
        dispatch_pkt_o.instr = head_i.instr;
        dispatch_pkt_o.rs1   = rs1_data_i;
        dispatch_pkt_o.rs2   = rs2_data_i;
      end
      e_src_fe_exc:
      begin
        dispatch_pkt_o.pc    = head_i.pc;
        dispatch_pkt_o.instr = head_i.instr;
        dispatch_pkt_o.exc   = head_i.exc;
      end
      e_src_late_wb:
      begin
        dispatch_pkt_o.wb_rd_addr = late_wb_i.rd_addr;
        dispatch_pkt_o.wb_w_v     = late_wb_i.w_v;
        // wb data rides in the rs1 slot
        dispatch_pkt_o.rs1        = late_wb_i.rd_data;
      end
      // resume, irq and idle carry nothing else
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/int_regfile.sv
// integer register file, one write port and two asynchronous read ports
`timescale 1ns/1ps
`default_nettype none

module int_regfile
  (input  logic                                  clk_i
   , input  logic                                rst_i

   , input  sched_pkg::wb_pkt_s                  wb_i

   , input  logic [sched_pkg::reg_addr_width_c-1:0] rs1_addr_i
   , input  logic [sched_pkg::reg_addr_width_c-1:0] rs2_addr_i
   , output logic [sched_pkg::xlen_c-1:0]        rs1_data_o
   , output logic [sched_pkg::xlen_c-1:0]        rs2_data_o
   );

  import sched_pkg::*;

  // x0 has no storage
  logic [xlen_c-1:0] regs_q [1:31];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (wb_i.w_v && (wb_i.rd_addr != '0))
    begin
      regs_q[wb_i.rd_addr] <= wb_i.rd_data;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

//--- source/issue_queue.sv
// issue queue FIFO with valid/ready push, head output, pop and clear
`timescale 1ns/1ps
`default_nettype none

module issue_queue
  #(parameter int queue_depth_p = 4
   )
  (input  logic                clk_i
   , input  logic              rst_i

   , input  sched_pkg::fe_entry_s fe_entry_i
   , input  logic              fe_v_i
   , output logic              fe_ready_o

   , input  logic              pop_i
   , input  logic              clear_i

   , output logic              head_v_o
   , output sched_pkg::fe_entry_s head_o
   );

  import sched_pkg::*;

  localparam int ptr_width_lp = $clog2(queue_depth_p);
  localparam logic [ptr_width_lp:0] full_count_lp = (ptr_width_lp+1)'(queue_depth_p);

  fe_entry_s mem_q [queue_depth_p];

  logic [ptr_width_lp-1:0] wr_ptr_q, rd_ptr_q;
  logic [ptr_width_lp:0]   count_q;
  logic                    push, pop;

  assign fe_ready_o = (count_q != full_count_lp);
  assign head_v_o   = (count_q != '0);
  assign head_o     = mem_q[rd_ptr_q];

  // clear wins over both a push and a pop in the same cycle
  assign push = fe_v_i & fe_ready_o & ~clear_i;
  assign pop  = pop_i & head_v_o & ~clear_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i | clear_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage only
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= fe_entry_i;
  end

endmodule

`default_nettype wire

//--- source/sched_control.sv
// dispatch source arbitration with late writeback yumi and queue pop
`timescale 1ns/1ps
`default_nettype none

module sched_control
  (input  logic                      head_v_i
   , input  sched_pkg::fetch_exc_e   head_exc_i

   , input  logic                    late_wb_v_i
   , input  logic                    late_wb_force_i
   , input  logic                    hazard_i
   , input  logic                    resume_i
   , input  logic                    irq_pending_i

   , output sched_pkg::dispatch_src_e src_o
   , output logic                    pop_o
   , output logic                    late_wb_yumi_o
   );

  import sched_pkg::*;

  logic queued;
  logic wb_v, resume_v, irq_v;

  // a held head never counts as queued
  assign queued = head_v_i & ~hazard_i;

  // late wb has no back-pressure, so force lets it jump the queue
  assign wb_v     = late_wb_v_i & (late_wb_force_i | ~queued);
  assign resume_v = ~late_wb_v_i & ~hazard_i & resume_i;
  assign irq_v    = ~late_wb_v_i & ~hazard_i & ~resume_i & irq_pending_i;

  always_comb
  begin
    if (wb_v)
      src_o = e_src_late_wb;
    else if (resume_v)
      src_o = e_src_resume;
    else if (irq_v)
      src_o = e_src_irq;
    else if (queued && (head_exc_i != e_exc_none))
      src_o = e_src_fe_exc;
    else if (queued)
      src_o = e_src_fe_instr;
    else
      src_o = e_src_idle;
  end

  assign pop_o          = (src_o == e_src_fe_instr) | (src_o == e_src_fe_exc);
  assign late_wb_yumi_o = wb_v;

endmodule

`default_nettype wire

//--- source/sched_pkg.sv
// widths, enums and packet structs shared by the issue scheduler
`default_nettype none

package sched_pkg;

  // data and address widths
  localparam int xlen_c           = 64;
  localparam int pc_width_c       = 39;
  localparam int instr_width_c    = 32;
  localparam int reg_addr_width_c = 5;

  // rs1 and rs2 fields of a RISC-V instruction
  localparam int rs1_lsb_c = 15;
  localparam int rs2_lsb_c = 20;

  typedef enum logic [1:0]
  {
    e_exc_none          = 2'd0,
    e_exc_access_fault  = 2'd1,
    e_exc_page_fault    = 2'd2,
    e_exc_illegal_instr = 2'd3
  } fetch_exc_e;

  typedef enum logic [2:0]
  {
    e_src_idle     = 3'd0,
    e_src_late_wb  = 3'd1,
    e_src_resume   = 3'd2,
    e_src_irq      = 3'd3,
    e_src_fe_instr = 3'd4,
    e_src_fe_exc   = 3'd5
  } dispatch_src_e;

  // one fetched entry, as written by the front end
  typedef struct packed
  {
    logic [pc_width_c-1:0]    pc;
    logic [instr_width_c-1:0] instr;
    fetch_exc_e               exc;
  } fe_entry_s;

  // integer and late writebacks share this layout
  typedef struct packed
  {
    logic                        w_v;
    logic [reg_addr_width_c-1:0] rd_addr;
    logic [xlen_c-1:0]           rd_data;
  } wb_pkt_s;

  typedef struct packed
  {
    logic                        v;
    dispatch_src_e               src;
    logic [pc_width_c-1:0]       pc;
    logic [instr_width_c-1:0]    instr;
    logic [xlen_c-1:0]           rs1;
    logic [xlen_c-1:0]           rs2;
    fetch_exc_e                  exc;
    // late writeback target
    logic [reg_addr_width_c-1:0] wb_rd_addr;
    logic                        wb_w_v;
  } dispatch_pkt_s;

endpackage

`default_nettype wire
